// File: design/dispatch_config.svh
`ifndef DISPATCH_CONFIG_SVH
`define DISPATCH_CONFIG_SVH

// instructions per cycle from rename
`define RENAME_WIDTH 2

// integer dispatch queue
`define INTDQ_DEPTH 16
`define INTDQ_DISP_WID 2

// immediate buffer
`define IMMBUF_SIZE 8
`define IMMBUF_READPORT_NUM 2
`define IMMBUF_CLEARPORT_NUM 2

// sizes that set the index widths
`define ROB_SIZE 32
`define PHYS_REG_NUM 64
`define FTQ_SIZE 16

`endif

// File: design/dispatch_pkg.sv
`include "dispatch_config.svh"

package dispatch_pkg;

    // index types
    typedef logic [$clog2(`ROB_SIZE)-1:0]     rob_idx_t;
    typedef logic [$clog2(`IMMBUF_SIZE)-1:0]  irob_idx_t;
    typedef logic [$clog2(`PHYS_REG_NUM)-1:0] preg_idx_t;
    typedef logic [4:0]                       lreg_idx_t;
    typedef logic [$clog2(`FTQ_SIZE)-1:0]     ftq_idx_t;
    typedef logic [3:0]                       ftq_offset_t;

    // value types
    typedef logic [19:0] imm_t;
    typedef logic [3:0]  except_t;
    typedef logic [6:0]  micop_t;

    // target execution block
    typedef enum logic {
        INT_BLOCK = 1'b0,
        MEM_BLOCK = 1'b1
    } disp_que_e;

    typedef struct packed {
        ftq_idx_t    ftq_idx;
        ftq_offset_t ftq_offset;
        logic        is_rvc;
        logic        is_mv;
        disp_que_e   disp_que;
        logic        use_imm;
        imm_t        imm;
        logic        rd_wen;
        lreg_idx_t   ilrd_idx;
        preg_idx_t   iprd_idx;
        preg_idx_t   prev_iprd_idx;
        preg_idx_t   iprs1_idx;
        preg_idx_t   iprs2_idx;
        micop_t      micop;
        logic        has_except;
        except_t     except_code;
    } ren_info_t;

    typedef struct packed {
        ftq_idx_t    ftq_idx;
        ftq_offset_t ftq_offset;
        logic        is_rvc;
        logic        is_mv;
        logic        has_rd;
        lreg_idx_t   ilrd_idx;
        preg_idx_t   iprd_idx;
        preg_idx_t   prev_iprd_idx;
    } rob_entry_t;

    typedef struct packed {
        ftq_idx_t  ftq_idx;
        rob_idx_t  rob_idx;
        irob_idx_t irob_idx;
        logic      rd_wen;
        preg_idx_t iprd_idx;
        preg_idx_t iprs1_idx;
        preg_idx_t iprs2_idx;
        logic      use_imm;
        micop_t    micop;
    } intdq_entry_t;

    typedef struct packed {
        rob_idx_t rob_idx;
        except_t  except_code;
    } except_wb_t;

endpackage

// File: design/disp_ctrl.sv
`timescale 1ns/1ns
`include "dispatch_config.svh"

module disp_ctrl
    import dispatch_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`RENAME_WIDTH-1:0] i_enq_vld,
    input  ren_info_t                i_enq_inst [`RENAME_WIDTH],
    input  logic                     i_can_insert_rob,
    input  rob_idx_t                 i_alloc_rob_idx [`RENAME_WIDTH],
    input  logic                     i_intdq_can_enq,
    input  logic                     i_imm_can_alloc,
    input  irob_idx_t                i_imm_alloc_idx [`RENAME_WIDTH],
    output logic                     o_stall,
    output logic                     o_disp_fire,
    output logic                     o_insert_rob_vld,
    output logic [`RENAME_WIDTH-1:0] o_insert_rob_req,
    output logic [`RENAME_WIDTH-1:0] o_insert_rob_is_mv,
    output rob_entry_t               o_new_rob_entry [`RENAME_WIDTH],
    output logic [`RENAME_WIDTH-1:0] o_intdq_enq_req,
    output intdq_entry_t             o_intdq_enq_data [`RENAME_WIDTH],
    output logic [`RENAME_WIDTH-1:0] o_imm_alloc_req,
    output imm_t                     o_imm_data [`RENAME_WIDTH],
    output logic                     o_except_wb_vld,
    output except_wb_t               o_except_wb_info
);
    logic       can_dispatch;
    logic       disp_fire;
    logic       exc_hit;
    except_wb_t exc_rec;
    logic       except_vld_q;
    except_wb_t except_info_q;

    // whole group goes or nothing goes
    assign can_dispatch = i_can_insert_rob && i_intdq_can_enq && i_imm_can_alloc;
    assign disp_fire    = can_dispatch && i_enq_vld[0];

    assign o_stall          = i_enq_vld[0] && !can_dispatch;
    assign o_disp_fire      = disp_fire;
    assign o_insert_rob_vld = disp_fire;
    assign o_insert_rob_req = i_enq_vld;

    always_comb begin
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            o_insert_rob_is_mv[i] = i_enq_inst[i].is_mv;
            // moves complete in the ROB and skip the int queue
            o_intdq_enq_req[i] = i_enq_vld[i] && (i_enq_inst[i].disp_que == INT_BLOCK)
                                 && !i_enq_inst[i].is_mv;
            o_imm_alloc_req[i] = i_enq_vld[i] && i_enq_inst[i].use_imm;
            o_imm_data[i]      = i_enq_inst[i].imm;

            o_new_rob_entry[i] = '{
                ftq_idx:       i_enq_inst[i].ftq_idx,
                ftq_offset:    i_enq_inst[i].ftq_offset,
                is_rvc:        i_enq_inst[i].is_rvc,
                is_mv:         i_enq_inst[i].is_mv,
                has_rd:        i_enq_inst[i].rd_wen,
                ilrd_idx:      i_enq_inst[i].ilrd_idx,
                iprd_idx:      i_enq_inst[i].iprd_idx,
                prev_iprd_idx: i_enq_inst[i].prev_iprd_idx
            };

            o_intdq_enq_data[i] = '{
                ftq_idx:   i_enq_inst[i].ftq_idx,
                rob_idx:   i_alloc_rob_idx[i],
                irob_idx:  i_imm_alloc_idx[i],
                rd_wen:    i_enq_inst[i].rd_wen,
                iprd_idx:  i_enq_inst[i].iprd_idx,
                iprs1_idx: i_enq_inst[i].iprs1_idx,
                iprs2_idx: i_enq_inst[i].iprs2_idx,
                use_imm:   i_enq_inst[i].use_imm,
                micop:     i_enq_inst[i].micop
            };
        end
    end

    // oldest frontend exception, lowest slot wins
    always_comb begin
        exc_hit = 1'b0;
        exc_rec = '0;
        for (int i = `RENAME_WIDTH - 1; i >= 0; i--) begin
            if (i_enq_vld[i] && i_enq_inst[i].has_except) begin
                exc_hit             = 1'b1;
                exc_rec.rob_idx     = i_alloc_rob_idx[i];
                exc_rec.except_code = i_enq_inst[i].except_code;
            end
        end
    end

    // writeback one cycle after dispatch
    always_ff @(posedge clk) begin
        if (rst) begin
            except_vld_q <= 1'b0;
        end else begin
            except_vld_q <= disp_fire && exc_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (disp_fire && exc_hit) begin
            except_info_q <= exc_rec;
        end
    end

    assign o_except_wb_vld  = except_vld_q;
    assign o_except_wb_info = except_info_q;

endmodule

// File: design/int_disp_queue.sv
`timescale 1ns/1ns
`include "dispatch_config.svh"

module int_disp_queue
    import dispatch_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_flush,
    input  logic                       i_enq_fire,
    input  logic [`RENAME_WIDTH-1:0]   i_enq_req,
    input  intdq_entry_t               i_enq_data [`RENAME_WIDTH],
    input  logic                       i_deq_stall,
    output logic                       o_can_enq,
    output logic [`INTDQ_DISP_WID-1:0] o_deq_vld,
    output intdq_entry_t               o_deq_data [`INTDQ_DISP_WID]
);
    localparam int PTR_W = $clog2(`INTDQ_DEPTH);
    localparam int CNT_W = PTR_W + 1;
    localparam int OUT_W = $clog2(`INTDQ_DISP_WID + 1);

    intdq_entry_t     mem [`INTDQ_DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_nxt;
    logic [PTR_W-1:0] wr_ptr [`RENAME_WIDTH];
    logic [CNT_W-1:0] req_cnt;
    logic [CNT_W-1:0] enq_cnt;
    logic [CNT_W-1:0] deq_cnt;
    // entries shown on the dequeue port, frozen during a stall
    logic [OUT_W-1:0] shown;
    logic [OUT_W-1:0] shown_nxt;

    // pack requested slots at the tail in slot order
    always_comb begin
        req_cnt = '0;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            wr_ptr[i] = tail + req_cnt[PTR_W-1:0];
            req_cnt   = req_cnt + CNT_W'(i_enq_req[i]);
        end
    end

    assign enq_cnt   = i_enq_fire ? req_cnt : '0;
    assign deq_cnt   = i_deq_stall ? '0 : CNT_W'(shown);
    assign count_nxt = count + enq_cnt - deq_cnt;

    always_comb begin
        if (count_nxt > CNT_W'(`INTDQ_DISP_WID)) begin
            shown_nxt = OUT_W'(`INTDQ_DISP_WID);
        end else begin
            shown_nxt = count_nxt[OUT_W-1:0];
        end
    end

    // room for a full rename group
    assign o_can_enq = count <= CNT_W'(`INTDQ_DEPTH - `RENAME_WIDTH);

    always_comb begin
        for (int j = 0; j < `INTDQ_DISP_WID; j++) begin
            o_deq_vld[j]  = shown > OUT_W'(j);
            o_deq_data[j] = mem[head + PTR_W'(j)];
        end
    end

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            shown <= '0;
        end else begin
            head  <= head + deq_cnt[PTR_W-1:0];
            tail  <= tail + enq_cnt[PTR_W-1:0];
            count <= count_nxt;
            if (!i_deq_stall) begin
                shown <= shown_nxt;
            end
        end
    end

    // squash drops the write as well
    always_ff @(posedge clk) begin
        if (i_enq_fire && !i_flush) begin
            for (int i = 0; i < `RENAME_WIDTH; i++) begin
                if (i_enq_req[i]) begin
                    mem[wr_ptr[i]] <= i_enq_data[i];
                end
            end
        end
    end

endmodule

// File: design/imm_buffer.sv
`timescale 1ns/1ns
`include "dispatch_config.svh"

module imm_buffer
    import dispatch_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             i_flush,
    input  logic                             i_alloc_fire,
    input  logic [`RENAME_WIDTH-1:0]         i_alloc_req,
    input  imm_t                             i_alloc_data [`RENAME_WIDTH],
    input  irob_idx_t                        i_read_idx [`IMMBUF_READPORT_NUM],
    input  logic [`IMMBUF_CLEARPORT_NUM-1:0] i_clear_vld,
    input  irob_idx_t                        i_clear_idx [`IMMBUF_CLEARPORT_NUM],
    output logic                             o_can_alloc,
    output irob_idx_t                        o_alloc_idx [`RENAME_WIDTH],
    output imm_t                             o_read_data [`IMMBUF_READPORT_NUM]
);
    localparam int CNT_W   = $bits(irob_idx_t) + 1;
    localparam int RET_WID = 2;

    imm_t             mem [`IMMBUF_SIZE];
    logic [`IMMBUF_SIZE-1:0] done;
    irob_idx_t        head;
    irob_idx_t        tail;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] req_cnt;
    logic [CNT_W-1:0] alloc_cnt;
    logic [CNT_W-1:0] ret_cnt;

    // consecutive indices from the tail for requesting slots
    always_comb begin
        req_cnt = '0;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            o_alloc_idx[i] = tail + irob_idx_t'(req_cnt);
            req_cnt        = req_cnt + CNT_W'(i_alloc_req[i]);
        end
    end

    assign alloc_cnt   = i_alloc_fire ? req_cnt : '0;
    assign o_can_alloc = count <= CNT_W'(`IMMBUF_SIZE - `RENAME_WIDTH);

    // retire done entries from the head, stop at the first pending one
    always_comb begin
        logic chain;
        chain   = 1'b1;
        ret_cnt = '0;
        for (int k = 0; k < RET_WID; k++) begin
            chain   = chain && (count > CNT_W'(k)) && done[head + irob_idx_t'(k)];
            ret_cnt = ret_cnt + CNT_W'(chain);
        end
    end

    always_comb begin
        for (int r = 0; r < `IMMBUF_READPORT_NUM; r++) begin
            o_read_data[r] = mem[i_read_idx[r]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            head  <= head + irob_idx_t'(ret_cnt);
            tail  <= tail + irob_idx_t'(alloc_cnt);
            count <= count + alloc_cnt - ret_cnt;
            for (int i = 0; i < `RENAME_WIDTH; i++) begin
                if (i_alloc_fire && i_alloc_req[i]) begin
                    done[o_alloc_idx[i]] <= 1'b0;
                end
            end
            // writeback clears may arrive in any order
            for (int c = 0; c < `IMMBUF_CLEARPORT_NUM; c++) begin
                if (i_clear_vld[c]) begin
                    done[i_clear_idx[c]] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_alloc_fire && !i_flush) begin
            for (int i = 0; i < `RENAME_WIDTH; i++) begin
                if (i_alloc_req[i]) begin
                    mem[o_alloc_idx[i]] <= i_alloc_data[i];
                end
            end
        end
    end

endmodule

// File: design/dispatch_top.sv
`timescale 1ns/1ns
`include "dispatch_config.svh"

module dispatch_top
    import dispatch_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             i_squash,
    input  logic [`RENAME_WIDTH-1:0]         i_enq_vld,
    input  ren_info_t                        i_enq_inst [`RENAME_WIDTH],
    input  logic                             i_can_insert_rob,
    input  rob_idx_t                         i_alloc_rob_idx [`RENAME_WIDTH],
    input  logic                             i_int_stall,
    input  irob_idx_t                        i_read_irob_idx [`IMMBUF_READPORT_NUM],
    input  logic [`IMMBUF_CLEARPORT_NUM-1:0] i_clear_irob_vld,
    input  irob_idx_t                        i_clear_irob_idx [`IMMBUF_CLEARPORT_NUM],
    output logic                             o_stall,
    output logic                             o_insert_rob_vld,
    output logic [`RENAME_WIDTH-1:0]         o_insert_rob_req,
    output logic [`RENAME_WIDTH-1:0]         o_insert_rob_is_mv,
    output rob_entry_t                       o_new_rob_entry [`RENAME_WIDTH],
    output logic [`INTDQ_DISP_WID-1:0]       o_int_deq_vld,
    output intdq_entry_t                     o_int_deq_info [`INTDQ_DISP_WID],
    output imm_t                             o_read_imm [`IMMBUF_READPORT_NUM],
    output logic                             o_except_wb_vld,
    output except_wb_t                       o_except_wb_info
);
    logic                     disp_fire;
    logic                     intdq_can_enq;
    logic [`RENAME_WIDTH-1:0] intdq_enq_req;
    intdq_entry_t             intdq_enq_data [`RENAME_WIDTH];
    logic                     imm_can_alloc;
    logic [`RENAME_WIDTH-1:0] imm_alloc_req;
    imm_t                     imm_data [`RENAME_WIDTH];
    irob_idx_t                imm_alloc_idx [`RENAME_WIDTH];

    disp_ctrl u_disp_ctrl (
        .clk                (clk),
        .rst                (rst),
        .i_enq_vld          (i_enq_vld),
        .i_enq_inst         (i_enq_inst),
        .i_can_insert_rob   (i_can_insert_rob),
        .i_alloc_rob_idx    (i_alloc_rob_idx),
        .i_intdq_can_enq    (intdq_can_enq),
        .i_imm_can_alloc    (imm_can_alloc),
        .i_imm_alloc_idx    (imm_alloc_idx),
        .o_stall            (o_stall),
        .o_disp_fire        (disp_fire),
        .o_insert_rob_vld   (o_insert_rob_vld),
        .o_insert_rob_req   (o_insert_rob_req),
        .o_insert_rob_is_mv (o_insert_rob_is_mv),
        .o_new_rob_entry    (o_new_rob_entry),
        .o_intdq_enq_req    (intdq_enq_req),
        .o_intdq_enq_data   (intdq_enq_data),
        .o_imm_alloc_req    (imm_alloc_req),
        .o_imm_data         (imm_data),
        .o_except_wb_vld    (o_except_wb_vld),
        .o_except_wb_info   (o_except_wb_info)
    );

    int_disp_queue u_int_disp_queue (
        .clk         (clk),
        .rst         (rst),
        .i_flush     (i_squash),
        .i_enq_fire  (disp_fire),
        .i_enq_req   (intdq_enq_req),
        .i_enq_data  (intdq_enq_data),
        .i_deq_stall (i_int_stall),
        .o_can_enq   (intdq_can_enq),
        .o_deq_vld   (o_int_deq_vld),
        .o_deq_data  (o_int_deq_info)
    );

    imm_buffer u_imm_buffer (
        .clk          (clk),
        .rst          (rst),
        .i_flush      (i_squash),
        .i_alloc_fire (disp_fire),
        .i_alloc_req  (imm_alloc_req),
        .i_alloc_data (imm_data),
        .i_read_idx   (i_read_irob_idx),
        .i_clear_vld  (i_clear_irob_vld),
        .i_clear_idx  (i_clear_irob_idx),
        .o_can_alloc  (imm_can_alloc),
        .o_alloc_idx  (imm_alloc_idx),
        .o_read_data  (o_read_imm)
    );

endmodule

// File: dv/dispatch_chk.sv
`timescale 1ns/1ns
`include "dispatch_config.svh"

module dispatch_chk (
    input logic                       clk,
    input logic                       rst,
    input logic [`RENAME_WIDTH-1:0]   i_enq_vld,
    input logic                       o_stall,
    input logic                       o_insert_rob_vld,
    input logic [`INTDQ_DISP_WID-1:0] o_int_deq_vld
);
    // set by any failed assertion, watched by the testbench
    logic violation = 1'b0;

    // ones form a run starting at bit 0
    function automatic logic from_bit0(logic [7:0] v);
        return (v & (v + 8'd1)) == 8'd0;
    endfunction

    a_enq_contig: assert property (@(posedge clk) disable iff (rst)
        from_bit0(8'(i_enq_vld)))
    else begin
        $error("rename valid bits are not contiguous from slot 0");
        violation = 1'b1;
    end

    // a stalled group never reaches the ROB
    a_stall_vs_insert: assert property (@(posedge clk) disable iff (rst)
        !(o_stall && o_insert_rob_vld))
    else begin
        $error("stall and ROB insert are high in the same cycle");
        violation = 1'b1;
    end

    a_deq_contig: assert property (@(posedge clk) disable iff (rst)
        from_bit0(8'(o_int_deq_vld)))
    else begin
        $error("integer dequeue valid bits are not contiguous");
        violation = 1'b1;
    end

endmodule

// File: dv/dispatch_tb.sv
`timescale 1ns/1ns
`include "dispatch_config.svh"

module dispatch_tb
    import dispatch_pkg::*;
();
    logic                             clk;
    logic                             rst;
    logic                             i_squash;
    logic [`RENAME_WIDTH-1:0]         i_enq_vld;
    ren_info_t                        i_enq_inst [`RENAME_WIDTH];
    logic                             i_can_insert_rob;
    rob_idx_t                         i_alloc_rob_idx [`RENAME_WIDTH];
    logic                             i_int_stall;
    irob_idx_t                        i_read_irob_idx [`IMMBUF_READPORT_NUM];
    logic [`IMMBUF_CLEARPORT_NUM-1:0] i_clear_irob_vld;
    irob_idx_t                        i_clear_irob_idx [`IMMBUF_CLEARPORT_NUM];
    logic                             o_stall;
    logic                             o_insert_rob_vld;
    logic [`RENAME_WIDTH-1:0]         o_insert_rob_req;
    logic [`RENAME_WIDTH-1:0]         o_insert_rob_is_mv;
    rob_entry_t                       o_new_rob_entry [`RENAME_WIDTH];
    logic [`INTDQ_DISP_WID-1:0]       o_int_deq_vld;
    intdq_entry_t                     o_int_deq_info [`INTDQ_DISP_WID];
    imm_t                             o_read_imm [`IMMBUF_READPORT_NUM];
    logic                             o_except_wb_vld;
    except_wb_t                       o_except_wb_info;

    typedef struct packed {
        logic                           stall;
        logic                           fire;
        logic [`RENAME_WIDTH-1:0]       rob_req;
        rob_entry_t [`RENAME_WIDTH-1:0] rob_ent;
        logic                           exc_vld;
        except_wb_t                     exc;
    } group_pred_t;

    // expected queue contents in dispatch order, with their immediates
    intdq_entry_t            exp_q [$];
    imm_t                    exp_imm [$];
    // buffer entries that are finished and may be cleared
    irob_idx_t               clear_q [$];
    int                      exp_nvld;
    int                      imm_head;
    int                      imm_tail;
    int                      imm_cnt;
    logic [`IMMBUF_SIZE-1:0] imm_done;
    logic                    pend_exc_vld;
    except_wb_t              pend_exc;
    int                      fills;
    int                      tries;

    dispatch_top u_dispatch_top (.*);

    bind dispatch_top dispatch_chk u_dispatch_chk (
        .clk              (clk),
        .rst              (rst),
        .i_enq_vld        (i_enq_vld),
        .o_stall          (o_stall),
        .o_insert_rob_vld (o_insert_rob_vld),
        .o_int_deq_vld    (o_int_deq_vld)
    );

    always #20 clk = ~clk;

    always @(posedge u_dispatch_top.u_dispatch_chk.violation) begin
        fail_now("a bound checker assertion failed");
    end

    task automatic fail_now(string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic expect_eq(string name, logic [63:0] got, logic [63:0] exp);
        assert (got === exp)
        else fail_now($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    // whole group goes only when ROB, queue and buffer all have room
    function automatic group_pred_t predict_group(
        logic [`RENAME_WIDTH-1:0] vld,
        ren_info_t                inst [`RENAME_WIDTH],
        rob_idx_t                 rob_idx [`RENAME_WIDTH],
        logic                     rob_ok,
        int                       q_used,
        int                       imm_used
    );
        group_pred_t p;
        logic        room;
        room      = rob_ok && (q_used + `RENAME_WIDTH <= `INTDQ_DEPTH)
                    && (imm_used + `RENAME_WIDTH <= `IMMBUF_SIZE);
        p.stall   = vld[0] && !room;
        p.fire    = vld[0] && room;
        p.rob_req = vld;
        p.exc_vld = 1'b0;
        p.exc     = '0;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            p.rob_ent[i] = {inst[i].ftq_idx, inst[i].ftq_offset, inst[i].is_rvc,
                            inst[i].is_mv, inst[i].rd_wen, inst[i].ilrd_idx,
                            inst[i].iprd_idx, inst[i].prev_iprd_idx};
            // first excepting slot is the oldest
            if (vld[i] && inst[i].has_except && !p.exc_vld) begin
                p.exc_vld = 1'b1;
                p.exc     = '{rob_idx: rob_idx[i], except_code: inst[i].except_code};
            end
        end
        return p;
    endfunction

    task automatic clear_model();
        exp_q.delete();
        exp_imm.delete();
        clear_q.delete();
        exp_nvld = 0;
        imm_head = 0;
        imm_tail = 0;
        imm_cnt  = 0;
        imm_done = '0;
    endtask

    // fill mode sends two immediate users to the mem block every cycle
    task automatic next_cycle(bit fill, bit clr, bit squash);
        logic [95:0] bits;
        int          n;
        @(posedge clk);
        #5;
        n         = $urandom_range(`RENAME_WIDTH);
        i_enq_vld = fill ? '1 : `RENAME_WIDTH'((1 << n) - 1);
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            bits               = {$urandom, $urandom, $urandom};
            i_enq_inst[i]      = bits[$bits(ren_info_t)-1:0];
            i_alloc_rob_idx[i] = rob_idx_t'($urandom);
            if (fill) begin
                i_enq_inst[i].use_imm  = 1'b1;
                i_enq_inst[i].disp_que = MEM_BLOCK;
            end
        end
        i_can_insert_rob = fill || ($urandom_range(3) != 0);
        i_int_stall      = !fill && ($urandom_range(3) == 0);
        i_squash         = squash;
        // read back the immediates of the shown queue entries
        for (int j = 0; j < `IMMBUF_READPORT_NUM; j++) begin
            i_read_irob_idx[j] = o_int_deq_info[j].irob_idx;
        end
        for (int c = 0; c < `IMMBUF_CLEARPORT_NUM; c++) begin
            i_clear_irob_vld[c] = clr && (clear_q.size() > 0);
            i_clear_irob_idx[c] = i_clear_irob_vld[c] ? clear_q.pop_front() : '0;
        end
    endtask

    always @(posedge clk) begin : compare
        group_pred_t  p;
        intdq_entry_t e;
        irob_idx_t    idx;
        int           n;
        if (rst) begin
            clear_model();
            pend_exc_vld = 1'b0;
        end else begin
            p = predict_group(i_enq_vld, i_enq_inst, i_alloc_rob_idx, i_can_insert_rob,
                              exp_q.size(), imm_cnt);
            expect_eq("o_stall", o_stall, p.stall);
            expect_eq("o_insert_rob_vld", o_insert_rob_vld, p.fire);
            expect_eq("o_insert_rob_req", o_insert_rob_req, p.rob_req);
            for (int i = 0; i < `RENAME_WIDTH; i++) begin
                expect_eq("o_insert_rob_is_mv", o_insert_rob_is_mv[i], i_enq_inst[i].is_mv);
                if (i_enq_vld[i]) begin
                    expect_eq("o_new_rob_entry", o_new_rob_entry[i], p.rob_ent[i]);
                end
            end

            expect_eq("o_except_wb_vld", o_except_wb_vld, pend_exc_vld);
            if (pend_exc_vld) begin
                expect_eq("o_except_wb_info", o_except_wb_info, pend_exc);
            end
            pend_exc_vld = p.fire && p.exc_vld;
            pend_exc     = p.exc;

            expect_eq("o_int_deq_vld", o_int_deq_vld, (1 << exp_nvld) - 1);
            for (int j = 0; j < exp_nvld; j++) begin
                expect_eq("o_int_deq_info", o_int_deq_info[j], exp_q[j]);
                if (exp_q[j].use_imm) begin
                    expect_eq("o_read_imm", o_read_imm[j], exp_imm[j]);
                end
            end
            if (!i_int_stall) begin
                for (int j = 0; j < exp_nvld; j++) begin
                    if (exp_q[0].use_imm) begin
                        clear_q.push_back(exp_q[0].irob_idx);
                    end
                    void'(exp_q.pop_front());
                    void'(exp_imm.pop_front());
                end
            end

            // up to two cleared entries retire from the head
            n = 0;
            while (n < 2 && n < imm_cnt && imm_done[(imm_head + n) % `IMMBUF_SIZE]) begin
                n++;
            end
            imm_head = (imm_head + n) % `IMMBUF_SIZE;
            imm_cnt  = imm_cnt - n;
            for (int c = 0; c < `IMMBUF_CLEARPORT_NUM; c++) begin
                if (i_clear_irob_vld[c]) begin
                    imm_done[i_clear_irob_idx[c]] = 1'b1;
                end
            end

            if (p.fire) begin
                n = 0;
                for (int i = 0; i < `RENAME_WIDTH; i++) begin
                    idx = irob_idx_t'(imm_tail + n);
                    if (i_enq_vld[i] && i_enq_inst[i].use_imm) begin
                        imm_done[idx] = 1'b0;
                        n++;
                    end
                    if (i_enq_vld[i] && i_enq_inst[i].disp_que == INT_BLOCK
                        && !i_enq_inst[i].is_mv) begin
                        e = '{ftq_idx: i_enq_inst[i].ftq_idx, rob_idx: i_alloc_rob_idx[i],
                              irob_idx: idx, rd_wen: i_enq_inst[i].rd_wen,
                              iprd_idx: i_enq_inst[i].iprd_idx,
                              iprs1_idx: i_enq_inst[i].iprs1_idx,
                              iprs2_idx: i_enq_inst[i].iprs2_idx,
                              use_imm: i_enq_inst[i].use_imm, micop: i_enq_inst[i].micop};
                        exp_q.push_back(e);
                        exp_imm.push_back(i_enq_inst[i].imm);
                    end else if (i_enq_vld[i] && i_enq_inst[i].use_imm) begin
                        // no queue entry reads it, free it right away
                        clear_q.push_back(idx);
                    end
                end
                imm_tail = (imm_tail + n) % `IMMBUF_SIZE;
                imm_cnt  = imm_cnt + n;
            end

            // shown entries hold during an int block stall
            if (!i_int_stall) begin
                exp_nvld = (exp_q.size() < `INTDQ_DISP_WID) ? exp_q.size() : `INTDQ_DISP_WID;
            end
            if (i_squash) begin
                clear_model();
            end
        end
    end

    initial begin
        void'($urandom(71118));
        clk              = 1'b0;
        rst              = 1'b1;
        i_squash         = 1'b0;
        i_enq_vld        = '0;
        i_enq_inst       = '{default: '0};
        i_can_insert_rob = 1'b0;
        i_alloc_rob_idx  = '{default: '0};
        i_int_stall      = 1'b0;
        i_read_irob_idx  = '{default: '0};
        i_clear_irob_vld = '0;
        i_clear_irob_idx = '{default: '0};
        repeat (3) @(posedge clk);
        #5;
        rst = 1'b0;

        // mixed traffic with clears flowing
        repeat (400) next_cycle(1'b0, 1'b1, 1'b0);

        // squash, then the whole buffer must be allocatable again
        next_cycle(1'b0, 1'b0, 1'b1);
        fills = 0;
        next_cycle(1'b1, 1'b0, 1'b0);
        while (!o_stall) begin
            if (fills == 20) begin
                fail_now("o_stall never rose while the immediate buffer was filling");
            end
            fills++;
            next_cycle(1'b1, 1'b0, 1'b0);
        end
        assert (fills == `IMMBUF_SIZE / `RENAME_WIDTH)
        else fail_now("immediate buffer stalled before its full capacity was allocated");

        // clearing the head entries releases the stall
        tries = 0;
        while (o_stall) begin
            if (tries == 20) begin
                fail_now("o_stall stayed high after the head entries were cleared");
            end
            tries++;
            next_cycle(1'b1, 1'b1, 1'b0);
        end

        repeat (100) next_cycle(1'b0, 1'b1, 1'b0);
        @(posedge clk);
        #1;
        $display("TEST OK");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+design
design/dispatch_pkg.sv
design/disp_ctrl.sv
design/int_disp_queue.sv
design/imm_buffer.sv
design/dispatch_top.sv
dv/dispatch_chk.sv
dv/dispatch_tb.sv

// File: Bender.yml
package:
  name: dispatch

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/dispatch_pkg.sv
      - design/disp_ctrl.sv
      - design/int_disp_queue.sv
      - design/imm_buffer.sv
      - design/dispatch_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/dispatch_chk.sv
      - dv/dispatch_tb.sv
